// ==== Bender.yml ====
package:
  name: ahbLsu

sources:
  # Shared definitions first, then the blocks, then the top level
  - files:
      - src/ahbLsuPkg.sv
      - src/busFsm.sv
      - src/busDataPath.sv
      - src/ahbSramSlave.sv
      - src/ahbLsuTop.sv

  # Testbench with its case table header
  - target: test
    include_dirs:
      - include
    files:
      - verification/ahbLsuTb.sv

// ==== ahbLsu.f ====
+incdir+include
src/ahbLsuPkg.sv
src/busFsm.sv
src/busDataPath.sv
src/ahbSramSlave.sv
src/ahbLsuTop.sv
verification/ahbLsuTb.sv

// ==== src/ahbLsuPkg.sv ====
// Word-only AHB-Lite load/store settings; memWords must be a power of two, memWaitStates >= 0
package ahbLsuPkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Address and data are both one 32-bit word wide
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  ////////////////////
  // Slave memory
  ////////////////////

  // Number of words in the SRAM, upper address bits wrap onto it
  localparam int memWords = 64;
  localparam int memIdxWidth = $clog2(memWords);

  // HREADY-low cycles inserted in every data phase
  localparam int memWaitStates = 2;

  // Counter must stay at least one bit wide even with zero wait states
  localparam int waitCntWidth = (memWaitStates > 0) ? $clog2(memWaitStates + 1) : 1;

  ////////////////////
  // Enumerations
  ////////////////////

  // Controller state, release is a keyword so the last state carries a suffix
  typedef enum logic [1:0] {addrPhase, dataPhase, releasePhase} busStateType;

  // Standard AHB transfer type encoding
  typedef enum logic [1:0] {idle = 2'b00, busy = 2'b01, nonSeq = 2'b10, seq = 2'b11} htransType;

  // Request opcode, any nonzero value is a request and bit 0 selects write
  typedef enum logic [1:0] {busNone = 2'b00, busWrite = 2'b01, busRead = 2'b10} busRwType;

endpackage

// ==== src/ahbLsuTop.sv ====
// One master and one slave share the bus; only one transfer is in flight at a time
`timescale 1ns/1ps

module ahbLsuTop (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  ahbLsuPkg::busRwType             busRw,
  input  logic [ahbLsuPkg::addrWidth-1:0] adr,
  input  logic [ahbLsuPkg::dataWidth-1:0] writeData,
  input  logic                            cpuBusy,
  output logic                            busStall,
  output logic                            busCommitted,
  output logic [ahbLsuPkg::dataWidth-1:0] readData
);

  ////////////////////
  // Internal AHB-Lite bus
  ////////////////////

  ahbLsuPkg::htransType            HTRANS;
  logic                            HWRITE;
  logic [ahbLsuPkg::addrWidth-1:0] HADDR;
  logic [ahbLsuPkg::dataWidth-1:0] HWDATA;
  logic [ahbLsuPkg::dataWidth-1:0] HRDATA;
  logic                            HREADY;

  // Controller to data path strobes
  logic captureEn;
  logic addrAccept;

  // Phase sequencing and requester stall
  busFsm uBusFsm (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .busRw        (busRw),
    .cpuBusy      (cpuBusy),
    .HREADY       (HREADY),
    .busStall     (busStall),
    .busCommitted (busCommitted),
    .captureEn    (captureEn),
    .addrAccept   (addrAccept),
    .HTRANS       (HTRANS),
    .HWRITE       (HWRITE)
  );

  // Address, store data and read capture
  busDataPath uBusDataPath (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .adr        (adr),
    .writeData  (writeData),
    .addrAccept (addrAccept),
    .captureEn  (captureEn),
    .HREADY     (HREADY),
    .HRDATA     (HRDATA),
    .HADDR      (HADDR),
    .HWDATA     (HWDATA),
    .readData   (readData)
  );

  // On-chip SRAM with fixed wait states
  ahbSramSlave uAhbSramSlave (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HTRANS  (HTRANS),
    .HADDR   (HADDR),
    .HWRITE  (HWRITE),
    .HWDATA  (HWDATA),
    .HRDATA  (HRDATA),
    .HREADY  (HREADY)
  );

endmodule

// ==== src/ahbSramSlave.sv ====
// Word transfers only: no HSIZE, no error response, address bits above the array wrap
`timescale 1ns/1ps

module ahbSramSlave (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  ahbLsuPkg::htransType            HTRANS,
  input  logic [ahbLsuPkg::addrWidth-1:0] HADDR,
  input  logic                            HWRITE,
  input  logic [ahbLsuPkg::dataWidth-1:0] HWDATA,
  output logic [ahbLsuPkg::dataWidth-1:0] HRDATA,
  output logic                            HREADY
);

  // Storage array, contents come up undefined
  logic [ahbLsuPkg::dataWidth-1:0] mem [ahbLsuPkg::memWords];

  // Address phase as latched at acceptance
  logic [ahbLsuPkg::memIdxWidth-1:0] wordIdx;
  logic                              writeFlag;

  // Transfer tracking
  logic                               pending;
  logic [ahbLsuPkg::waitCntWidth-1:0] waitCnt;
  logic                               addrTaken;
  logic                               lastCycle;

  ////////////////////
  // Handshake
  ////////////////////

  // A nonSeq transfer is taken only when the previous one is not stalling the bus
  assign addrTaken = (HTRANS == ahbLsuPkg::nonSeq) && HREADY;

  // The data phase completes once the wait counter has drained
  assign lastCycle = pending && (waitCnt == '0);

  // Ready is high when idle and in the completing cycle of a transfer
  assign HREADY = !pending || lastCycle;

  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      pending <= 1'b0;
      waitCnt <= '0;
    end else if (addrTaken) begin
      // A new address phase may overlap the completing cycle
      pending <= 1'b1;
      waitCnt <= ahbLsuPkg::waitCntWidth'(ahbLsuPkg::memWaitStates);
    end else if (lastCycle) begin
      pending <= 1'b0;
    end else if (pending) begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  ////////////////////
  // Address latch
  ////////////////////

  // Byte offset bits are dropped and the upper bits are ignored
  always_ff @(posedge HCLK) begin
    if (addrTaken) begin
      wordIdx   <= HADDR[ahbLsuPkg::memIdxWidth+1:2];
      writeFlag <= HWRITE;
    end
  end

  ////////////////////
  // Memory access
  ////////////////////

  // Store lands at the edge that ends the data phase
  always_ff @(posedge HCLK) begin
    if (lastCycle && writeFlag) begin
      mem[wordIdx] <= HWDATA;
    end
  end

  // Read word is presented combinationally from the latched index
  assign HRDATA = mem[wordIdx];

endmodule

// ==== src/busDataPath.sv ====
// HADDR is passed through unregistered, so adr must stay stable during the address phase
`timescale 1ns/1ps

module busDataPath (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahbLsuPkg::addrWidth-1:0] adr,
  input  logic [ahbLsuPkg::dataWidth-1:0] writeData,
  input  logic                            addrAccept,
  input  logic                            captureEn,
  input  logic                            HREADY,
  input  logic [ahbLsuPkg::dataWidth-1:0] HRDATA,
  output logic [ahbLsuPkg::addrWidth-1:0] HADDR,
  output logic [ahbLsuPkg::dataWidth-1:0] HWDATA,
  output logic [ahbLsuPkg::dataWidth-1:0] readData
);

  logic [ahbLsuPkg::dataWidth-1:0] writeDataReg;
  logic [ahbLsuPkg::dataWidth-1:0] readDataReg;

  ////////////////////
  // Address drive
  ////////////////////

  // The requester holds adr during its request, which covers the address phase
  assign HADDR = adr;

  ////////////////////
  // Write data
  ////////////////////

  // Store data is taken at the address phase and held through the data phase
  // since the requester is free to move writeData once the phase has begun
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      writeDataReg <= '0;
    end else if (addrAccept) begin
      writeDataReg <= writeData;
    end
  end

  assign HWDATA = writeDataReg;

  ////////////////////
  // Read capture
  ////////////////////

  // HRDATA is only valid in the cycle that ends the data phase
  // Stores never raise captureEn, so readData keeps the last loaded word
  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      readDataReg <= '0;
    end else if (captureEn && HREADY) begin
      readDataReg <= HRDATA;
    end
  end

  assign readData = readDataReg;

endmodule

// ==== src/busFsm.sv ====
// Single outstanding transfer only; the requester must hold busRw steady while busStall is high
`timescale 1ns/1ps

module busFsm (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  ahbLsuPkg::busRwType  busRw,
  input  logic                 cpuBusy,
  input  logic                 HREADY,
  output logic                 busStall,
  output logic                 busCommitted,
  output logic                 captureEn,
  output logic                 addrAccept,
  output ahbLsuPkg::htransType HTRANS,
  output logic                 HWRITE
);

  ahbLsuPkg::busStateType currState;
  ahbLsuPkg::busStateType nextState;
  logic                   busReq;

  // Any nonzero opcode is a request
  assign busReq = |busRw;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (!HRESETn) begin
      currState <= ahbLsuPkg::addrPhase;
    end else begin
      currState <= nextState;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    case (currState)
      // Leave only once the slave has taken the address phase
      ahbLsuPkg::addrPhase: begin
        nextState = (busReq && HREADY) ? ahbLsuPkg::dataPhase : ahbLsuPkg::addrPhase;
      end
      // Wait states from the slave keep us here
      ahbLsuPkg::dataPhase: begin
        nextState = HREADY ? ahbLsuPkg::releasePhase : ahbLsuPkg::dataPhase;
      end
      // Hold the bus while the core is still busy with the result
      ahbLsuPkg::releasePhase: begin
        nextState = cpuBusy ? ahbLsuPkg::releasePhase : ahbLsuPkg::addrPhase;
      end
      default: begin
        nextState = ahbLsuPkg::addrPhase;
      end
    endcase
  end

  ////////////////////
  // Output decode
  ////////////////////

  // Address phase is accepted when a request meets a ready slave
  assign addrAccept = (currState == ahbLsuPkg::addrPhase) && busReq && HREADY;
  assign HTRANS     = addrAccept ? ahbLsuPkg::nonSeq : ahbLsuPkg::idle;
  assign HWRITE     = busRw[0];

  // Stall from the first request cycle until the data phase completes
  assign busStall     = ((currState == ahbLsuPkg::addrPhase) && busReq) ||
                        (currState == ahbLsuPkg::dataPhase);
  assign busCommitted = (currState != ahbLsuPkg::addrPhase);
  // Only loads capture read data, and busRw is still held in the data phase
  assign captureEn    = (currState == ahbLsuPkg::dataPhase) && !busRw[0];

endmodule

// ==== include/ahbLsuTbCases.svh ====
// Directed LSU cases; aliasing rows assume memWords = 64, so byte offset 256 lands on word 0
`ifndef AHB_LSU_TB_CASES_SVH
`define AHB_LSU_TB_CASES_SVH

////////////////////
// Case table
////////////////////

localparam int numCases = 15;

// One column per array, indexed by case number
ahbLsuPkg::busRwType             opTab    [numCases];
logic [ahbLsuPkg::addrWidth-1:0] adrTab   [numCases];
logic [ahbLsuPkg::dataWidth-1:0] wdataTab [numCases];
int                              busyTab  [numCases];
logic [ahbLsuPkg::dataWidth-1:0] expTab   [numCases];

// Store one row of the table
task automatic putCase(input int idx, input ahbLsuPkg::busRwType op,
                       input logic [ahbLsuPkg::addrWidth-1:0] a,
                       input logic [ahbLsuPkg::dataWidth-1:0] wdata,
                       input int busyHold,
                       input logic [ahbLsuPkg::dataWidth-1:0] expData);
  opTab[idx]    = op;
  adrTab[idx]   = a;
  wdataTab[idx] = wdata;
  busyTab[idx]  = busyHold;
  expTab[idx]   = expData;
endtask

// Columns: case, opcode, address, write data, cpuBusy hold cycles, expected readData
// For a store the expected readData is the last value read, since stores never capture
task automatic loadCaseTable();
  putCase(0,  ahbLsuPkg::busWrite, 32'h0000_0000, 32'h1111_1111, 0, 32'h0000_0000);
  putCase(1,  ahbLsuPkg::busWrite, 32'h0000_0004, 32'h2222_2222, 0, 32'h0000_0000);
  putCase(2,  ahbLsuPkg::busRead,  32'h0000_0000, 32'h0000_0000, 0, 32'h1111_1111);
  putCase(3,  ahbLsuPkg::busRead,  32'h0000_0004, 32'h0000_0000, 2, 32'h2222_2222);
  putCase(4,  ahbLsuPkg::busWrite, 32'h0000_00fc, 32'hdead_beef, 0, 32'h2222_2222);
  putCase(5,  ahbLsuPkg::busRead,  32'h0000_00fc, 32'h0000_0000, 0, 32'hdead_beef);
  // Word 66 wraps onto word 2
  putCase(6,  ahbLsuPkg::busWrite, 32'h0000_0108, 32'ha5a5_5a5a, 0, 32'hdead_beef);
  putCase(7,  ahbLsuPkg::busRead,  32'h0000_0008, 32'h0000_0000, 1, 32'ha5a5_5a5a);
  putCase(8,  ahbLsuPkg::busWrite, 32'h0000_0008, 32'h0f0f_0f0f, 3, 32'ha5a5_5a5a);
  putCase(9,  ahbLsuPkg::busWrite, 32'h0000_0010, 32'h1234_5678, 0, 32'ha5a5_5a5a);
  putCase(10, ahbLsuPkg::busRead,  32'h0000_0108, 32'h0000_0000, 0, 32'h0f0f_0f0f);
  // Byte offset bits are ignored
  putCase(11, ahbLsuPkg::busRead,  32'h0000_0011, 32'h0000_0000, 0, 32'h1234_5678);
  putCase(12, ahbLsuPkg::busRead,  32'h8000_0000, 32'h0000_0000, 2, 32'h1111_1111);
  putCase(13, ahbLsuPkg::busWrite, 32'h8000_0000, 32'hcafe_f00d, 0, 32'h1111_1111);
  putCase(14, ahbLsuPkg::busRead,  32'h0000_0000, 32'h0000_0000, 0, 32'hcafe_f00d);
endtask

`endif

// ==== verification/ahbLsuTb.sv ====
// Drives ahbLsuTop through table and random transfers; reads only hit words already written
`timescale 1ns/1ps

module ahbLsuTb;

  logic                            HCLK;
  logic                            HRESETn;
  ahbLsuPkg::busRwType             busRw;
  logic [ahbLsuPkg::addrWidth-1:0] adr;
  logic [ahbLsuPkg::dataWidth-1:0] writeData;
  logic                            cpuBusy;
  logic                            busStall;
  logic                            busCommitted;
  logic [ahbLsuPkg::dataWidth-1:0] readData;

  `include "ahbLsuTbCases.svh"

  // Stall length of every transfer, address cycle plus data phase
  localparam int expStall  = 2 + ahbLsuPkg::memWaitStates;
  localparam int waitLimit = 64;
  localparam int numRandom = 40;

  // Reference memory of the random phase
  logic [ahbLsuPkg::dataWidth-1:0] refMem   [ahbLsuPkg::memWords];
  bit                              refValid [ahbLsuPkg::memWords];
  logic [ahbLsuPkg::dataWidth-1:0] lastRead;
  int                              seed;

  ahbLsuTop DUT (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .busRw        (busRw),
    .adr          (adr),
    .writeData    (writeData),
    .cpuBusy      (cpuBusy),
    .busStall     (busStall),
    .busCommitted (busCommitted),
    .readData     (readData)
  );

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abortRun();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Word index as the slave sees it, byte offset dropped and upper bits wrapped
  function automatic int wordIndex(input logic [ahbLsuPkg::addrWidth-1:0] a);
    return int'((a >> 2) % ahbLsuPkg::memWords);
  endfunction

  // One requester transfer followed by its release and an idle check
  task automatic runTransfer(input ahbLsuPkg::busRwType op,
                             input logic [ahbLsuPkg::addrWidth-1:0] a,
                             input logic [ahbLsuPkg::dataWidth-1:0] wdata,
                             input int busyHold,
                             input logic [ahbLsuPkg::dataWidth-1:0] expData);
    int cnt;
    @(posedge HCLK);
    #1;
    busRw     = op;
    adr       = a;
    writeData = wdata;
    // cpuBusy only matters once the controller reaches release
    cpuBusy   = (busyHold > 0);
    cnt = 0;
    @(negedge HCLK);
    while (busStall) begin
      cnt++;
      if (cnt > waitLimit) begin
        $display("Timeout: busStall stayed high for more than %0d cycles", waitLimit);
        abortRun();
      end
      @(negedge HCLK);
    end
    assert (cnt == expStall) else begin
      $display("mismatch at %0t: busStall high %0d cycles, expected %0d", $time, cnt, expStall);
      abortRun();
    end
    assert (readData === expData) else begin
      $display("mismatch at %0t: readData %h, expected %h (adr %h)", $time, readData, expData, a);
      abortRun();
    end
    assert (busCommitted === 1'b1) else begin
      $display("mismatch at %0t: busCommitted low in the completing cycle", $time);
      abortRun();
    end
    // Release is stretched, a dummy read offered here must be ignored
    for (int k = 1; k <= busyHold; k++) begin
      @(posedge HCLK);
      #1;
      if (k < busyHold) begin
        busRw = ahbLsuPkg::busRead;
      end else begin
        busRw   = ahbLsuPkg::busNone;
        cpuBusy = 1'b0;
      end
      @(negedge HCLK);
      assert (busStall === 1'b0 && busCommitted === 1'b1) else begin
        $display("mismatch at %0t: stall %b committed %b during release", $time, busStall,
                 busCommitted);
        abortRun();
      end
    end
    @(posedge HCLK);
    #1;
    busRw   = ahbLsuPkg::busNone;
    cpuBusy = 1'b0;
    @(negedge HCLK);
    // Back in addrPhase with no request
    assert (busStall === 1'b0 && busCommitted === 1'b0) else begin
      $display("mismatch at %0t: stall %b committed %b when idle", $time, busStall, busCommitted);
      abortRun();
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int                              idx;
    int                              gap;
    int                              hold;
    logic [31:0]                     rnd;
    logic [ahbLsuPkg::addrWidth-1:0] a;
    logic [ahbLsuPkg::dataWidth-1:0] d;
    seed      = 32'hffeb;
    HRESETn   = 1'b0;
    busRw     = ahbLsuPkg::busNone;
    adr       = '0;
    writeData = '0;
    cpuBusy   = 1'b0;
    lastRead  = '0;
    for (int i = 0; i < ahbLsuPkg::memWords; i++) begin
      refValid[i] = 1'b0;
    end
    loadCaseTable();
    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    @(negedge HCLK);
    assert (busStall === 1'b0 && busCommitted === 1'b0) else begin
      $display("mismatch at %0t: stall %b committed %b after reset", $time, busStall,
               busCommitted);
      abortRun();
    end

    // Directed table, stores also feed the reference memory
    for (int i = 0; i < numCases; i++) begin
      runTransfer(opTab[i], adrTab[i], wdataTab[i], busyTab[i], expTab[i]);
      if (opTab[i] == ahbLsuPkg::busWrite) begin
        refMem[wordIndex(adrTab[i])]   = wdataTab[i];
        refValid[wordIndex(adrTab[i])] = 1'b1;
      end else begin
        lastRead = expTab[i];
      end
    end

    // Random mix with idle gaps and release holds
    for (int n = 0; n < numRandom; n++) begin
      rnd  = $random(seed);
      gap  = rnd[3:2];
      hold = rnd[5:4] % 3;
      repeat (gap) @(posedge HCLK);
      a   = $random(seed);
      d   = $random(seed);
      idx = wordIndex(a);
      // Move a read onto the next word that has been written
      for (int s = 0; s < ahbLsuPkg::memWords && !refValid[idx]; s++) begin
        idx = (idx + 1) % ahbLsuPkg::memWords;
      end
      if (rnd[0] || !refValid[idx]) begin
        runTransfer(ahbLsuPkg::busWrite, a, d, hold, lastRead);
        refMem[wordIndex(a)]   = d;
        refValid[wordIndex(a)] = 1'b1;
      end else begin
        a[ahbLsuPkg::memIdxWidth+1:2] = idx[ahbLsuPkg::memIdxWidth-1:0];
        runTransfer(ahbLsuPkg::busRead, a, d, hold, refMem[idx]);
        lastRead = refMem[idx];
      end
    end

    $display("Regression passed");
    $finish;
  end

endmodule
